//--- files.f
mem_pkg.sv
core_pkg.sv
dbus_if.sv
commit_if.sv
exception_commit.sv
commit_latch.sv
data_commit.sv
commit_stage.sv
tb_commit_stage.sv

//--- Bender.yml
package:
  name: commit_stage

sources:
  - mem_pkg.sv
  - core_pkg.sv
  - dbus_if.sv
  - commit_if.sv
  - exception_commit.sv
  - commit_latch.sv
  - data_commit.sv
  - commit_stage.sv
  - target: test
    files:
      - tb_commit_stage.sv

//--- tb_commit_stage.sv
module tb_commit_stage;
    import core_pkg::*;
    import mem_pkg::*;

    localparam int    NUM_PAIRS  = 400;
    localparam int    MAX_WAIT   = 50;
    localparam word_t EXC_VECTOR = 32'hbfc00380;

    // what C2 must show when a pair commits
    typedef struct packed {
        rf_write_t [1:0] w;
        logic            redir;
        word_t           redir_pc;
        logic            exc_v;
        exception_t      exc;
    } expect_t;

    logic            clk;
    logic            rst_n;
    slot_t [1:0]     in_pair;
    logic            first_cycle;
    logic [5:0]      ext_int;
    word_t           status;
    logic            finish;
    rf_write_t [1:0] rf_w;
    logic            redirect_valid;
    word_t           redirect_pc;
    logic            exception_valid;
    exception_t      exception_data;
    logic            dmem_req;
    logic            dmem_is_write;
    size_t           dmem_size;
    word_t           dmem_addr;
    word_t           dmem_wdata;
    logic [3:0]      dmem_byte_en;
    logic            dmem_addr_ok;
    logic            dmem_data_ok;
    word_t           dmem_rdata;

    word_t   rng = 32'd46499;
    word_t   ref_mem [64];
    word_t   bus_mem [64];
    expect_t exp_q [$];
    int      acc_count;
    word_t   last_addr;
    logic    last_write;
    size_t   last_size;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      timeouts = 0;

    commit_stage #(
        .INT_LINES  (6),
        .EXC_VECTOR (EXC_VECTOR)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_pair         (in_pair),
        .first_cycle     (first_cycle),
        .ext_int         (ext_int),
        .status          (status),
        .finish          (finish),
        .rf_w            (rf_w),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .exception_valid (exception_valid),
        .exception_data  (exception_data),
        .dmem_req        (dmem_req),
        .dmem_is_write   (dmem_is_write),
        .dmem_size       (dmem_size),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .dmem_byte_en    (dmem_byte_en),
        .dmem_addr_ok    (dmem_addr_ok),
        .dmem_data_ok    (dmem_data_ok),
        .dmem_rdata      (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t fill_word(input int idx);
        logic [5:0] i;
        i = idx[5:0];
        return {2'b10, i, 8'(i * 7 + 3), ~i, 2'b01, {2'b00, i} ^ 8'ha5};
    endfunction

    function automatic slot_t make_slot(input word_t pc, input logic allow_mem);
        slot_t      s;
        word_t      r;
        word_t      a;
        int         sel;
        logic [1:0] off;

        r = next_rand();
        a = next_rand();
        s = '0;
        sel = r[11:8];
        s.valid  = r[2:0] != 3'd0;
        s.pc     = pc;
        s.result = next_rand();
        s.target = {a[31:2], 2'b00};
        s.dest   = r[7:3];
        if (sel < 6)
            s.op = OP_ALU;
        else if (sel < 9)
            s.op = allow_mem ? OP_LOAD : OP_ALU;
        else if (sel < 11)
            s.op = allow_mem ? OP_STORE : OP_ALU;
        else if (sel < 14)
            s.op = OP_BRANCH;
        else if (sel == 14)
            s.op = OP_SYSCALL;
        else
            s.op = OP_ERET;
        s.wen    = (s.op == OP_ALU || s.op == OP_LOAD) && (r[12] || r[13]);
        s.taken  = s.op == OP_BRANCH && r[14];
        s.exc_in = (s.op == OP_ALU && r[20:16] == 5'd0) ? EXC_OV : EXC_NONE;
        case (r[22:21])
            2'd0:    s.size = SIZE_BYTE;
            2'd1:    s.size = SIZE_HALF;
            default: s.size = SIZE_WORD;
        endcase
        // about one access in eight off its boundary
        if (r[27:25] == 3'd0)
            off = s.size == SIZE_HALF ? {r[23], 1'b1} : (r[24:23] == 2'd0 ? 2'd1 : r[24:23]);
        else
            off = s.size == SIZE_BYTE ? r[24:23] : s.size == SIZE_HALF ? {r[23], 1'b0} : 2'd0;
        s.mem_addr = {24'h000010, a[5:0], off};
        return s;
    endfunction

    function automatic exc_code_t fault_of(input slot_t s);
        logic bad_align;
        bad_align = (s.size == SIZE_HALF && s.mem_addr[0]) ||
                    (s.size == SIZE_WORD && s.mem_addr[1:0] != 2'b00);
        if (!s.valid)
            return EXC_NONE;
        if (s.exc_in != EXC_NONE)
            return s.exc_in;
        if (s.op == OP_SYSCALL)
            return EXC_SYS;
        if (s.op == OP_LOAD && bad_align)
            return EXC_ADEL;
        if (s.op == OP_STORE && bad_align)
            return EXC_ADES;
        return EXC_NONE;
    endfunction

    function automatic word_t load_value(input word_t w, input size_t size, input logic [1:0] off);
        word_t b;
        b = w >> (8 * off);
        if (size == SIZE_BYTE)
            return {{24{b[7]}}, b[7:0]};
        if (size == SIZE_HALF)
            return {{16{b[15]}}, b[15:0]};
        return w;
    endfunction

    // reference model of one pair, also applies its store to ref_mem
    task automatic predict(input slot_t [1:0] p, input logic [5:0] lines, input word_t st,
                           output expect_t e, output logic mem_op, output word_t mem_addr,
                           output logic mem_write, output size_t mem_size);
        exc_code_t  code [2];
        logic       irq;
        logic [1:0] live;
        int         idx;
        int         sh;

        e = '0;
        mem_op = 1'b0;
        mem_addr = '0;
        mem_write = 1'b0;
        mem_size = SIZE_BYTE;
        irq = p[0].valid && (lines & st[15:10]) != 6'd0 && st[0] && !st[1];
        code[0] = fault_of(p[0]);
        code[1] = fault_of(p[1]);
        if (irq)
        begin
            e.exc_v = 1'b1;
            e.exc.code = EXC_INT;
            e.exc.epc = p[0].pc;
        end
        else if (code[0] != EXC_NONE)
        begin
            e.exc_v = 1'b1;
            e.exc.code = code[0];
            e.exc.epc = p[0].pc;
            if (code[0] == EXC_ADEL || code[0] == EXC_ADES)
                e.exc.badvaddr = p[0].mem_addr;
        end
        else if (code[1] != EXC_NONE)
        begin
            e.exc_v = 1'b1;
            e.exc.code = code[1];
            e.exc.in_delay = p[0].valid && p[0].op == OP_BRANCH;
            e.exc.epc = e.exc.in_delay ? p[0].pc : p[1].pc;
            if (code[1] == EXC_ADEL || code[1] == EXC_ADES)
                e.exc.badvaddr = p[1].mem_addr;
        end
        live[0] = p[0].valid && !irq && code[0] == EXC_NONE;
        live[1] = p[1].valid && !e.exc_v;
        for (int k = 0; k < 2; k++)
        begin
            if (live[k])
            begin
                idx = p[k].mem_addr[7:2];
                sh = 8 * p[k].mem_addr[1:0];
                if (p[k].op == OP_LOAD || p[k].op == OP_STORE)
                begin
                    mem_op = 1'b1;
                    mem_addr = p[k].mem_addr;
                    mem_write = p[k].op == OP_STORE;
                    mem_size = p[k].size;
                end
                e.w[k].wen = p[k].wen;
                e.w[k].addr = p[k].dest;
                if (p[k].op == OP_LOAD)
                    e.w[k].data = load_value(ref_mem[idx], p[k].size, p[k].mem_addr[1:0]);
                else
                    e.w[k].data = p[k].result;
                if (p[k].op == OP_STORE && p[k].size == SIZE_BYTE)
                    ref_mem[idx][sh +: 8] = p[k].result[7:0];
                else if (p[k].op == OP_STORE && p[k].size == SIZE_HALF)
                    ref_mem[idx][sh +: 16] = p[k].result[15:0];
                else if (p[k].op == OP_STORE)
                    ref_mem[idx] = p[k].result;
            end
        end
        // lowest priority first, later matches override
        for (int k = 1; k >= 0; k--)
        begin
            if (live[k] && p[k].op == OP_BRANCH && p[k].taken)
            begin
                e.redir = 1'b1;
                e.redir_pc = p[k].target;
            end
        end
        for (int k = 1; k >= 0; k--)
        begin
            if (live[k] && p[k].op == OP_ERET)
            begin
                e.redir = 1'b1;
                e.redir_pc = p[k].target;
            end
        end
        if (e.exc_v)
        begin
            e.redir = 1'b1;
            e.redir_pc = EXC_VECTOR;
        end
    endtask

    task automatic check_val(input string what, input logic [95:0] exp, input logic [95:0] act);
        assert (exp === act)
        else
        begin
            value_errors++;
            $display("Fail %s: expected %0h, actual %0h", what, exp, act);
        end
    endtask

    task automatic check_commit(input expect_t e, input int n);
        for (int i = 0; i < 2; i++)
        begin
            check_val($sformatf("pair %0d rf_w[%0d].wen", n, i), e.w[i].wen, rf_w[i].wen);
            if (e.w[i].wen)
            begin
                check_val($sformatf("pair %0d rf_w[%0d].addr", n, i), e.w[i].addr, rf_w[i].addr);
                check_val($sformatf("pair %0d rf_w[%0d].data", n, i), e.w[i].data, rf_w[i].data);
            end
        end
        check_val($sformatf("pair %0d redirect_valid", n), e.redir, redirect_valid);
        if (e.redir)
            check_val($sformatf("pair %0d redirect_pc", n), e.redir_pc, redirect_pc);
        check_val($sformatf("pair %0d exception_valid", n), e.exc_v, exception_valid);
        if (e.exc_v)
            check_val($sformatf("pair %0d exception_data", n), e.exc, exception_data);
    endtask

    task automatic check_quiet(input int n);
        assert (!rf_w[0].wen && !rf_w[1].wen && !redirect_valid && !exception_valid)
        else
        begin
            protocol_errors++;
            $display("pair %0d: commit outputs active while finish is low", n);
        end
    endtask

    task automatic close_run();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    // data memory, one transfer at a time, random latencies
    initial
    begin
        int         phase;
        int         wait_cnt;
        logic       cur_write;
        word_t      cur_addr;
        word_t      cur_wdata;
        logic [3:0] cur_be;

        dmem_addr_ok = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rdata = '0;
        acc_count = 0;
        phase = 0;
        wait_cnt = 0;
        forever
        begin
            @(posedge clk);
            #10;
            dmem_addr_ok = 1'b0;
            dmem_data_ok = 1'b0;
            dmem_rdata = next_rand();
            if (phase == 0 && dmem_req)
            begin
                cur_addr = dmem_addr;
                cur_write = dmem_is_write;
                cur_wdata = dmem_wdata;
                cur_be = dmem_byte_en;
                wait_cnt = next_rand() % 4;
                phase = 1;
            end
            if (phase == 1)
            begin
                assert (dmem_req && dmem_addr == cur_addr && dmem_wdata == cur_wdata)
                else
                begin
                    protocol_errors++;
                    $display("dmem request dropped or changed before addr_ok at %0t", $time);
                end
                if (wait_cnt == 0)
                begin
                    dmem_addr_ok = 1'b1;
                    acc_count++;
                    last_addr = cur_addr;
                    last_write = cur_write;
                    last_size = dmem_size;
                    if (cur_write)
                    begin
                        for (int b = 0; b < 4; b++)
                        begin
                            if (cur_be[b])
                                bus_mem[cur_addr[7:2]][8 * b +: 8] = cur_wdata[8 * b +: 8];
                        end
                        phase = 0;
                    end
                    else
                    begin
                        wait_cnt = next_rand() % 4;
                        phase = 2;
                    end
                end
                else
                    wait_cnt--;
            end
            if (phase == 2)
            begin
                if (wait_cnt == 0)
                begin
                    dmem_data_ok = 1'b1;
                    dmem_rdata = bus_mem[cur_addr[7:2]];
                    phase = 0;
                end
                else
                    wait_cnt--;
            end
        end
    end

    initial
    begin
        slot_t [1:0] pair;
        expect_t     e;
        logic [5:0]  lines;
        word_t       stat;
        word_t       r;
        word_t       pc;
        logic        mem_op;
        word_t       mem_addr;
        logic        mem_write;
        size_t       mem_size;
        logic        prev_exc;
        logic        done;
        int          acc_start;

        rst_n = 1'b0;
        in_pair = '0;
        first_cycle = 1'b0;
        ext_int = '0;
        status = '0;
        for (int i = 0; i < 64; i++)
        begin
            ref_mem[i] = fill_word(i);
            bus_mem[i] = ref_mem[i];
        end
        pc = 32'h0040_0000;
        prev_exc = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        // latch is empty after reset
        exp_q.push_back('0);
        for (int n = 0; n <= NUM_PAIRS && timeouts == 0; n++)
        begin
            // a bubble follows an exception and ends the run
            if (n == NUM_PAIRS || prev_exc)
                pair = '0;
            else
            begin
                pair[0] = make_slot(pc, 1'b1);
                pair[1] = make_slot(pc + 4, !(pair[0].op inside {OP_LOAD, OP_STORE}));
            end
            pc += 8;
            r = next_rand();
            lines = r[1:0] == 2'd0 ? r[7:2] : 6'd0;
            r = next_rand();
            stat = {r[31:16], r[15:10], 8'h00, r[3] & r[2], r[1] | r[0]};
            predict(pair, lines, stat, e, mem_op, mem_addr, mem_write, mem_size);
            prev_exc = e.exc_v;
            @(posedge clk);
            #5;
            in_pair = pair;
            first_cycle = 1'b1;
            ext_int = lines;
            status = stat;
            acc_start = acc_count;
            done = 1'b0;
            for (int cyc = 0; cyc < MAX_WAIT && !done; cyc++)
            begin
                if (cyc > 0)
                begin
                    @(posedge clk);
                    #5;
                    first_cycle = 1'b0;
                    ext_int = '0;
                end
                #25;
                if (finish)
                begin
                    done = 1'b1;
                    check_commit(exp_q.pop_front(), n - 1);
                    check_val($sformatf("pair %0d bus transfers", n), mem_op,
                              acc_count - acc_start);
                    if (mem_op)
                    begin
                        check_val($sformatf("pair %0d dmem_addr", n), mem_addr, last_addr);
                        check_val($sformatf("pair %0d dmem_is_write", n), mem_write, last_write);
                        check_val($sformatf("pair %0d dmem_size", n), mem_size, last_size);
                    end
                    exp_q.push_back(e);
                end
                else
                    check_quiet(n);
            end
            if (!done)
            begin
                timeouts++;
                $display("timeout: pair %0d did not finish within %0d cycles", n, MAX_WAIT);
            end
        end
        if (timeouts == 0)
        begin
            for (int i = 0; i < 64; i++)
                check_val($sformatf("memory word %0d", i), ref_mem[i], bus_mem[i]);
        end
        close_run();
    end

endmodule

//--- commit_stage.sv
module commit_stage #(
    parameter int              INT_LINES  = 6,
    parameter core_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  core_pkg::slot_t [1:0]       in_pair,
    input  logic                        first_cycle,
    input  logic [INT_LINES-1:0]        ext_int,
    input  core_pkg::word_t             status,
    output logic                        finish,
    output core_pkg::rf_write_t [1:0]   rf_w,
    output logic                        redirect_valid,
    output core_pkg::word_t             redirect_pc,
    output logic                        exception_valid,
    output core_pkg::exception_t        exception_data,
    output logic                        dmem_req,
    output logic                        dmem_is_write,
    output mem_pkg::size_t              dmem_size,
    output core_pkg::word_t             dmem_addr,
    output core_pkg::word_t             dmem_wdata,
    output logic [3:0]                  dmem_byte_en,
    input  logic                        dmem_addr_ok,
    input  logic                        dmem_data_ok,
    input  core_pkg::word_t             dmem_rdata
);
    import core_pkg::*;

    slot_t [1:0] c1_pair;
    logic        c1_exc_valid;
    exception_t  c1_exc;
    logic        c1_exc_slot;
    logic        finish_c1;
    logic        finish_c2;

    dbus_if   bus ();
    commit_if c2 ();

    assign dmem_req          = bus.req.req;
    assign dmem_is_write     = bus.req.is_write;
    assign dmem_size         = bus.req.size;
    assign dmem_addr         = bus.req.addr;
    assign dmem_wdata        = bus.req.wdata;
    assign dmem_byte_en      = bus.req.byte_en;
    assign bus.resp.addr_ok  = dmem_addr_ok;
    assign bus.resp.data_ok  = dmem_data_ok;
    assign bus.resp.rdata    = dmem_rdata;

    // both sub-stages move together
    assign finish = finish_c1 & finish_c2;

    exception_commit #(
        .INT_LINES (INT_LINES)
    ) u_exception_commit (
        .clk, .rst_n, .in_pair, .first_cycle, .ext_int, .status,
        .bus       (bus.master),
        .finish,
        .out_pair  (c1_pair),
        .exc_valid (c1_exc_valid),
        .exc       (c1_exc),
        .exc_slot  (c1_exc_slot),
        .finish_c1
    );

    commit_latch u_commit_latch (
        .clk, .rst_n, .finish,
        .pair      (c1_pair),
        .exc_valid (c1_exc_valid),
        .exc       (c1_exc),
        .exc_slot  (c1_exc_slot),
        .c2        (c2.latch)
    );

    data_commit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_data_commit (
        .clk, .rst_n,
        .c2        (c2.consumer),
        .data_ok   (bus.resp.data_ok),
        .rdata     (bus.resp.rdata),
        .finish, .finish_c2, .rf_w, .redirect_valid, .redirect_pc,
        .exception_valid, .exception_data
    );

endmodule

//--- data_commit.sv
module data_commit #(
    parameter core_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
    input  logic                        clk,
    input  logic                        rst_n,
    commit_if.consumer                  c2,
    input  logic                        data_ok,
    input  core_pkg::word_t             rdata,
    input  logic                        finish,
    output logic                        finish_c2,
    output core_pkg::rf_write_t [1:0]   rf_w,
    output logic                        redirect_valid,
    output core_pkg::word_t             redirect_pc,
    output logic                        exception_valid,
    output core_pkg::exception_t        exception_data
);
    import core_pkg::*;
    import mem_pkg::*;

    logic       got;
    logic       own;
    word_t      held;
    word_t      load_word;
    word_t      shifted;
    word_t      load_result;
    logic [1:0] is_load;
    logic [1:0] is_eret;
    logic [1:0] is_taken;
    logic [1:0] keep;

    // C2 load still waiting for its data
    assign own       = c2.load_pending & ~got;
    assign finish_c2 = ~own | data_ok;

    // data_ok in the finish cycle without an own load belongs to the pair moving in
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            got <= 1'b0;
        else if (finish)
            got <= data_ok & ~own & ~exception_valid;
        else if (data_ok && own)
            got <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (data_ok && (finish || own))
            held <= rdata;
    end

    assign load_word = got ? held : rdata;
    assign shifted   = load_word >> {c2.load_off, 3'b000};

    always_comb
    begin
        case (c2.load_size)
            SIZE_BYTE: load_result = {{24{shifted[7]}}, shifted[7:0]};
            SIZE_HALF: load_result = {{16{shifted[15]}}, shifted[15:0]};
            default:   load_result = load_word;
        endcase
    end

    // slots at or behind the fault never write
    assign keep[0] = ~c2.exc_valid | c2.exc_slot;
    assign keep[1] = ~c2.exc_valid;

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            is_load[i]   = c2.pair[i].valid && c2.pair[i].op == OP_LOAD;
            is_eret[i]   = c2.pair[i].valid && c2.pair[i].op == OP_ERET;
            is_taken[i]  = c2.pair[i].valid && c2.pair[i].op == OP_BRANCH && c2.pair[i].taken;
            rf_w[i].wen  = finish & c2.pair[i].valid & c2.pair[i].wen & keep[i];
            rf_w[i].addr = is_load[i] ? c2.load_dest : c2.pair[i].dest;
            rf_w[i].data = is_load[i] ? load_result : c2.pair[i].result;
        end
    end

    assign exception_valid = finish & c2.exc_valid;
    assign exception_data  = c2.exc;
    assign redirect_valid  = finish & (c2.exc_valid | (|is_eret) | (|is_taken));

    always_comb
    begin
        if (c2.exc_valid)
            redirect_pc = EXC_VECTOR;
        else if (is_eret[0])
            redirect_pc = c2.pair[0].target;
        else if (is_eret[1])
            redirect_pc = c2.pair[1].target;
        else if (is_taken[0])
            redirect_pc = c2.pair[0].target;
        else if (is_taken[1])
            redirect_pc = c2.pair[1].target;
        else
            redirect_pc = '0;
    end

endmodule

//--- commit_latch.sv
module commit_latch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    finish,
    input  core_pkg::slot_t [1:0]   pair,
    input  logic                    exc_valid,
    input  core_pkg::exception_t    exc,
    input  logic                    exc_slot,
    commit_if.latch                 c2
);
    import core_pkg::*;
    import mem_pkg::*;

    logic [1:0] is_load;
    slot_t      load_slot;
    logic       flush;

    assign is_load[0] = pair[0].valid && pair[0].op == OP_LOAD;
    assign is_load[1] = pair[1].valid && pair[1].op == OP_LOAD;
    assign load_slot  = is_load[0] ? pair[0] : pair[1];

    // C2 reports its exception in the finish cycle
    assign flush = c2.exc_valid & finish;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            c2.pair         <= '0;
            c2.exc_valid    <= 1'b0;
            c2.exc          <= '0;
            c2.exc_slot     <= 1'b0;
            c2.load_pending <= 1'b0;
            c2.load_dest    <= '0;
            c2.load_size    <= SIZE_BYTE;
            c2.load_off     <= '0;
        end
        else if (flush)
        begin
            c2.pair         <= '0;
            c2.exc_valid    <= 1'b0;
            c2.exc          <= '0;
            c2.exc_slot     <= 1'b0;
            c2.load_pending <= 1'b0;
            c2.load_dest    <= '0;
            c2.load_size    <= SIZE_BYTE;
            c2.load_off     <= '0;
        end
        else if (finish)
        begin
            c2.pair         <= pair;
            c2.exc_valid    <= exc_valid;
            c2.exc          <= exc;
            c2.exc_slot     <= exc_slot;
            c2.load_pending <= is_load[0] | is_load[1];
            c2.load_dest    <= load_slot.dest;
            c2.load_size    <= load_slot.size;
            c2.load_off     <= load_slot.mem_addr[1:0];
        end
    end

endmodule

//--- exception_commit.sv
module exception_commit #(
    parameter int INT_LINES = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_pkg::slot_t [1:0]   in_pair,
    input  logic                    first_cycle,
    input  logic [INT_LINES-1:0]    ext_int,
    input  core_pkg::word_t         status,
    dbus_if.master                  bus,
    input  logic                    finish,
    output core_pkg::slot_t [1:0]   out_pair,
    output logic                    exc_valid,
    output core_pkg::exception_t    exc,
    output logic                    exc_slot,
    output logic                    finish_c1
);
    import core_pkg::*;
    import mem_pkg::*;

    exc_code_t [1:0] slot_code;
    logic [1:0]      slot_fault;
    logic [1:0]      is_mem;
    logic            irq_live;
    logic            irq_held;
    logic            irq;
    logic            accepted;
    slot_t           mem_slot;
    logic [3:0]      lane_mask;

    function automatic logic misaligned(size_t size, logic [1:0] off);
        return (size == SIZE_HALF && off[0]) || (size == SIZE_WORD && off != 2'b00);
    endfunction

    // execute cause first, then syscall, then alignment
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            slot_code[i] = EXC_NONE;
            if (in_pair[i].valid)
            begin
                if (in_pair[i].exc_in != EXC_NONE)
                    slot_code[i] = in_pair[i].exc_in;
                else if (in_pair[i].op == OP_SYSCALL)
                    slot_code[i] = EXC_SYS;
                else if (in_pair[i].op == OP_LOAD &&
                         misaligned(in_pair[i].size, in_pair[i].mem_addr[1:0]))
                    slot_code[i] = EXC_ADEL;
                else if (in_pair[i].op == OP_STORE &&
                         misaligned(in_pair[i].size, in_pair[i].mem_addr[1:0]))
                    slot_code[i] = EXC_ADES;
            end
            slot_fault[i] = slot_code[i] != EXC_NONE;
        end
    end

    // interrupt is sampled once per pair so a stall cannot change the decision
    assign irq_live = |(ext_int & status[STATUS_IM_LSB +: INT_LINES]) &
                      status[STATUS_IE] & ~status[STATUS_EXL];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            irq_held <= 1'b0;
        else if (first_cycle)
            irq_held <= irq_live;
    end

    assign irq       = in_pair[0].valid & (first_cycle ? irq_live : irq_held);
    assign exc_valid = irq | slot_fault[0] | slot_fault[1];
    assign exc_slot  = exc_valid & ~irq & ~slot_fault[0];

    always_comb
    begin
        exc = '0;
        if (irq)
        begin
            exc.code = EXC_INT;
            exc.epc  = in_pair[0].pc;
        end
        else if (slot_fault[0])
        begin
            exc.code = slot_code[0];
            exc.epc  = in_pair[0].pc;
            if (slot_code[0] inside {EXC_ADEL, EXC_ADES})
                exc.badvaddr = in_pair[0].mem_addr;
        end
        else if (slot_fault[1])
        begin
            // slot 1 behind a branch reports the branch pc
            exc.in_delay = in_pair[0].valid && in_pair[0].op == OP_BRANCH;
            exc.code     = slot_code[1];
            exc.epc      = exc.in_delay ? in_pair[0].pc : in_pair[1].pc;
            if (slot_code[1] inside {EXC_ADEL, EXC_ADES})
                exc.badvaddr = in_pair[1].mem_addr;
        end
    end

    always_comb
    begin
        out_pair          = in_pair;
        out_pair[0].valid = in_pair[0].valid & ~irq & ~slot_fault[0];
        out_pair[1].valid = in_pair[1].valid & ~exc_valid;
    end

    assign is_mem[0] = out_pair[0].valid && out_pair[0].op inside {OP_LOAD, OP_STORE};
    assign is_mem[1] = out_pair[1].valid && out_pair[1].op inside {OP_LOAD, OP_STORE};
    assign mem_slot  = is_mem[0] ? out_pair[0] : out_pair[1];

    always_comb
    begin
        case (mem_slot.size)
            SIZE_BYTE: lane_mask = 4'b0001 << mem_slot.mem_addr[1:0];
            SIZE_HALF: lane_mask = 4'b0011 << {mem_slot.mem_addr[1], 1'b0};
            default:   lane_mask = 4'b1111;
        endcase
    end

    assign bus.req.req      = (is_mem[0] | is_mem[1]) & ~accepted;
    assign bus.req.is_write = mem_slot.op == OP_STORE;
    assign bus.req.size     = mem_slot.size;
    assign bus.req.addr     = mem_slot.mem_addr;
    assign bus.req.byte_en  = lane_mask;
    assign bus.req.wdata    = mem_slot.size == SIZE_BYTE ? {4{mem_slot.result[7:0]}} :
                              mem_slot.size == SIZE_HALF ? {2{mem_slot.result[15:0]}} :
                              mem_slot.result;

    // request taken while C2 still stalls
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            accepted <= 1'b0;
        else if (finish)
            accepted <= 1'b0;
        else if (bus.req.req && bus.resp.addr_ok)
            accepted <= 1'b1;
    end

    assign finish_c1 = ~bus.req.req | bus.resp.addr_ok;

endmodule

//--- commit_if.sv
interface commit_if;
    import core_pkg::*;
    import mem_pkg::*;

    slot_t [1:0] pair;
    logic        exc_valid;
    exception_t  exc;
    logic        exc_slot;
    // the one load of the pair, if any
    logic        load_pending;
    logic [4:0]  load_dest;
    size_t       load_size;
    logic [1:0]  load_off;

    modport latch (
        output pair, exc_valid, exc, exc_slot,
        output load_pending, load_dest, load_size, load_off
    );

    modport consumer (
        input pair, exc_valid, exc, exc_slot,
        input load_pending, load_dest, load_size, load_off
    );

endinterface

//--- dbus_if.sv
interface dbus_if;
    import mem_pkg::*;

    dbus_req_t  req;
    dbus_resp_t resp;

    // master issues requests, slave answers
    modport master (
        output req,
        input  resp
    );

    modport slave (
        input  req,
        output resp
    );

endinterface

//--- core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;

    // what commit needs to know about an instruction
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_ALU     = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BRANCH  = 3'd4,
        OP_SYSCALL = 3'd5,
        OP_ERET    = 3'd6
    } op_t;

    // zero means no exception, so interrupt sits at 1
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_INT  = 5'd1,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_OV   = 5'd12
    } exc_code_t;

    // status register bit positions
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_LSB = 10;

    typedef struct packed {
        logic            valid;
        op_t             op;
        word_t           pc;
        word_t           result;
        word_t           mem_addr;
        mem_pkg::size_t  size;
        logic [4:0]      dest;
        logic            wen;
        logic            taken;
        word_t           target;
        exc_code_t       exc_in;
    } slot_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
        logic      in_delay;
    } exception_t;

    typedef struct packed {
        logic       wen;
        logic [4:0] addr;
        word_t      data;
    } rf_write_t;

endpackage

//--- mem_pkg.sv
package mem_pkg;

    // access width on the data bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    typedef struct packed {
        logic        req;
        logic        is_write;
        size_t       size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } dbus_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } dbus_resp_t;

endpackage
